//--- Bender.yml
package:
  name: id_stage

export_include_dirs:
  - .

sources:
  - decode_pkg.sv
  - inst_decoder.sv
  - regfile.sv
  - operand_fwd.sv
  - branch_unit.sv
  - id_stage.sv
  - target: test
    files:
      - id_stage_sva.sv
      - tb_id_stage.sv

//--- all.f
+incdir+.
decode_pkg.sv
inst_decoder.sv
regfile.sv
operand_fwd.sv
branch_unit.sv
id_stage.sv
id_stage_sva.sv
tb_id_stage.sv

//--- branch_unit.sv
`include "decode_macros.svh"

module branch_unit import decode_pkg::*; (
    input  br_kind_t         br_kind,
    input  logic [`XLEN-1:0] rj_value,
    input  logic [`XLEN-1:0] rkd_value,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] br_offs,
    input  logic             fire,
    input  logic             es_allowin,
    output br_t              br
);

    logic [`XLEN:0] diff;
    logic           eq;
    logic           lt;
    logic           ltu;
    logic           cond;

    // rj - rkd with carry out
    assign diff = {1'b0, rj_value} + {1'b0, ~rkd_value} + 1'b1;
    assign eq   = diff[`XLEN-1:0] == '0;
    assign lt   = (rj_value[`XLEN-1] & ~rkd_value[`XLEN-1])
                | (~(rj_value[`XLEN-1] ^ rkd_value[`XLEN-1]) & diff[`XLEN-1]);
    assign ltu  = ~diff[`XLEN];

    always_comb begin
        case (br_kind)
            BR_BEQ:                cond = eq;
            BR_BNE:                cond = !eq;
            BR_BLT:                cond = lt;
            BR_BGE:                cond = !lt;
            BR_BLTU:               cond = ltu;
            BR_BGEU:               cond = !ltu;
            BR_B, BR_BL, BR_JIRL:  cond = 1'b1;
            default:               cond = 1'b0;
        endcase
    end

    assign br.taken  = cond && fire;
    // only drop the fetch slot when the branch actually moves on
    assign br.cancel = br.taken && es_allowin;
    assign br.target = (br_kind == BR_JIRL) ? rj_value + br_offs : pc + br_offs;

endmodule

//--- decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define XLEN          32
`define REG_AW        5
`define REG_N         32
`define LINK_REG      5'd1
`define IMM_SHIFT_BR  2'b00

// major opcode, inst[31:26]
`define OP6_ALU       6'h00
`define OP6_LU12I     6'h05
`define OP6_PCADDU12I 6'h07
`define OP6_MEM       6'h0a
`define OP6_JIRL      6'h13
`define OP6_B         6'h14
`define OP6_BL        6'h15
`define OP6_BEQ       6'h16
`define OP6_BNE       6'h17
`define OP6_BLT       6'h18
`define OP6_BGE       6'h19
`define OP6_BLTU      6'h1a
`define OP6_BGEU      6'h1b

// inst[25:22], alu group
`define OP4_3R        4'h0
`define OP4_SHI       4'h1
`define OP4_SLTI      4'h8
`define OP4_SLTUI     4'h9
`define OP4_ADDI      4'ha
`define OP4_ANDI      4'hd
`define OP4_ORI       4'he
`define OP4_XORI      4'hf

// inst[25:22], memory group
`define OP4_LD_B      4'h0
`define OP4_LD_H      4'h1
`define OP4_LD_W      4'h2
`define OP4_ST_B      4'h4
`define OP4_ST_H      4'h5
`define OP4_ST_W      4'h6
`define OP4_LD_BU     4'h8
`define OP4_LD_HU     4'h9

// inst[21:20]
`define OP2_3R        2'h1
`define OP2_SHI       2'h0

// inst[19:15]
`define OP5_ADD       5'h00
`define OP5_SUB       5'h02
`define OP5_SLT       5'h04
`define OP5_SLTU      5'h05
`define OP5_NOR       5'h08
`define OP5_AND       5'h09
`define OP5_OR        5'h0a
`define OP5_XOR       5'h0b
`define OP5_SLL       5'h0e
`define OP5_SRL       5'h0f
`define OP5_SRA       5'h10
`define OP5_SLLI      5'h01
`define OP5_SRLI      5'h09
`define OP5_SRAI      5'h11

`endif

//--- decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

    typedef struct packed {
        logic [5:0]         op6;
        logic [3:0]         op4;
        logic [1:0]         op2;
        logic [4:0]         op5;
        logic [`REG_AW-1:0] rk;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]         opcode;
        logic [11:0]        i12;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [6:0]         opcode;
        logic [19:0]        i20;
        logic [`REG_AW-1:0] rd;
    } fmt_1ri20_t;

    // rj and rd double as offs26[25:16] for b and bl
    typedef struct packed {
        logic [5:0]         opcode;
        logic [15:0]        i16;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rd;
    } fmt_2ri16_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_1ri20_t fmt_1ri20;
        fmt_2ri16_t fmt_2ri16;
    } inst_u;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        inst_u            inst;
    } fs_to_ds_t;

    typedef struct packed {
        logic               valid;
        logic               blk;
        logic [`REG_AW-1:0] dest;
        logic [`XLEN-1:0]   data;
    } fwd_t;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
    } wb_t;

    typedef logic [11:0] alu_op_t;

    typedef struct packed {
        alu_op_t            alu_op;
        logic [4:0]         load_op;
        logic [2:0]         store_op;
        logic               res_from_mem;
        logic               src1_is_pc;
        logic               src2_is_imm;
        logic               gr_we;
        logic               mem_we;
        logic [`REG_AW-1:0] dest;
    } ctrl_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_B,
        BR_BL,
        BR_JIRL
    } br_kind_t;

    typedef struct packed {
        ctrl_t            ctrl;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] rj_value;
        logic [`XLEN-1:0] rkd_value;
        logic [`XLEN-1:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic             taken;
        logic             cancel;
        logic [`XLEN-1:0] target;
    } br_t;

endpackage

//--- id_stage.sv
`include "decode_macros.svh"

module id_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds,
    output logic      ds_allowin,
    input  logic      es_allowin,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es,
    input  fwd_t      es_fwd,
    input  fwd_t      ms_fwd,
    input  wb_t       wb,
    output br_t       br
);

    logic                    ds_valid;
    logic                    ds_ready_go;
    fs_to_ds_t               ds_r;
    ctrl_t                   ctrl;
    logic [`XLEN-1:0]        imm;
    br_kind_t                br_kind;
    logic [`XLEN-1:0]        br_offs;
    logic [1:0][`REG_AW-1:0] raddr;
    logic [1:0]              rused;
    logic [1:0][`XLEN-1:0]   rf_data;
    logic [1:0][`XLEN-1:0]   src_value;
    logic [1:0]              hazard;
    fwd_t                    ms_src;

    // memory stage results are always ready
    always_comb begin
        ms_src     = ms_fwd;
        ms_src.blk = 1'b0;
    end

    assign ds_ready_go    = ~|hazard;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (br.cancel) begin
            // wrong-path fetch packet is dropped here
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_r <= fs_to_ds;
        end
    end

    inst_decoder u_decoder (
        .inst    (ds_r.inst),
        .ctrl    (ctrl),
        .imm     (imm),
        .br_kind (br_kind),
        .br_offs (br_offs),
        .raddr   (raddr),
        .rused   (rused)
    );

    regfile u_regfile (
        .clk   (clk),
        .raddr (raddr),
        .rdata (rf_data),
        .wb    (wb)
    );

    for (genvar g = 0; g < 2; g++) begin : g_port
        operand_fwd u_fwd (
            .addr     (raddr[g]),
            .used     (rused[g]),
            .rf_value (rf_data[g]),
            .es_fwd   (es_fwd),
            .ms_fwd   (ms_src),
            .wb       (wb),
            .value    (src_value[g]),
            .hazard   (hazard[g])
        );
    end

    branch_unit u_branch (
        .br_kind    (br_kind),
        .rj_value   (src_value[0]),
        .rkd_value  (src_value[1]),
        .pc         (ds_r.pc),
        .br_offs    (br_offs),
        .fire       (ds_to_es_valid),
        .es_allowin (es_allowin),
        .br         (br)
    );

    assign ds_to_es = '{
        ctrl:      ctrl,
        imm:       imm,
        rj_value:  src_value[0],
        rkd_value: src_value[1],
        pc:        ds_r.pc
    };

endmodule

//--- id_stage_sva.sv
`include "decode_macros.svh"

module id_stage_sva import decode_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      fs_to_ds_valid,
    input fs_to_ds_t fs_to_ds,
    input logic      ds_allowin,
    input logic      es_allowin,
    input logic      ds_to_es_valid,
    input ds_to_es_t ds_to_es,
    input fwd_t      es_fwd,
    input fwd_t      ms_fwd,
    input wb_t       wb,
    input br_t       br,
    input logic      ds_valid
);

    logic [`XLEN-1:0]   exp_pc;
    logic [31:0]        exp_inst;
    logic [`XLEN-1:0]   shadow [`REG_N];
    logic [`REG_N-1:0]  written;
    logic [`REG_AW-1:0] rj;
    logic [`REG_AW-1:0] rkd;
    logic               is_addi;
    logic               is_st;
    logic               is_beq;
    logic               is_bne;
    logic               is_bl;
    logic               es_hit;
    logic               ms_hit;
    logic               wb_hit;
    logic [`XLEN-1:0]   beq_target;
    int                 err_count = 0;

    // packet last taken from fetch
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            exp_pc   <= fs_to_ds.pc;
            exp_inst <= fs_to_ds.inst;
        end
    end

    // register contents as seen on the write-back bus
    always_ff @(posedge clk) begin
        if (reset) begin
            written <= '0;
        end else if (wb.we && wb.waddr != '0) begin
            written[wb.waddr] <= 1'b1;
            shadow[wb.waddr]  <= wb.wdata;
        end
    end

    assign rj      = exp_inst[9:5];
    assign rkd     = exp_inst[4:0];
    assign is_addi = exp_inst[31:22] == {`OP6_ALU, `OP4_ADDI};
    assign is_st   = exp_inst[31:22] inside {{`OP6_MEM, `OP4_ST_B}, {`OP6_MEM, `OP4_ST_H},
                                             {`OP6_MEM, `OP4_ST_W}};
    assign is_beq  = exp_inst[31:26] == `OP6_BEQ;
    assign is_bne  = exp_inst[31:26] == `OP6_BNE;
    assign is_bl   = exp_inst[31:26] == `OP6_BL;

    assign es_hit     = rj != '0 && es_fwd.valid && es_fwd.dest == rj;
    assign ms_hit     = rj != '0 && ms_fwd.valid && ms_fwd.dest == rj;
    assign wb_hit     = wb.we && wb.waddr == rj;
    assign beq_target = exp_pc + {{14{exp_inst[25]}}, exp_inst[25:10], 2'b00};

    a_reset: assert property (@(posedge clk)
        reset |=> !ds_to_es_valid && !br.taken && !br.cancel)
    else begin
        err_count++;
        $error("ERR %0t: stage not idle after reset", $time);
    end

    a_pc: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> ds_to_es.pc == exp_pc)
    else begin
        err_count++;
        $error("ERR %0t: pc %h, expected %h", $time, ds_to_es.pc, exp_pc);
    end

    a_addi: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && is_addi |-> ds_to_es.imm == {{20{exp_inst[21]}}, exp_inst[21:10]}
            && ds_to_es.ctrl.dest == exp_inst[4:0] && ds_to_es.ctrl.gr_we)
    else begin
        err_count++;
        $error("ERR %0t: addi imm or dest wrong, imm %h", $time, ds_to_es.imm);
    end

    a_store: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && is_st |-> !ds_to_es.ctrl.gr_we && ds_to_es.ctrl.mem_we)
    else begin
        err_count++;
        $error("ERR %0t: store write enables wrong", $time);
    end

    a_fwd_es: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && es_hit |-> ds_to_es.rj_value == es_fwd.data)
    else begin
        err_count++;
        $error("ERR %0t: rj %h, expected execute data %h", $time, ds_to_es.rj_value,
               es_fwd.data);
    end

    a_fwd_ms: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_hit && ms_hit |-> ds_to_es.rj_value == ms_fwd.data)
    else begin
        err_count++;
        $error("ERR %0t: rj %h, expected memory data %h", $time, ds_to_es.rj_value,
               ms_fwd.data);
    end

    a_rf: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_hit && !ms_hit && !wb_hit && rj != '0 && written[rj]
            |-> ds_to_es.rj_value == shadow[rj])
    else begin
        err_count++;
        $error("ERR %0t: rj %h, expected register value %h", $time, ds_to_es.rj_value,
               shadow[rj]);
    end

    // load still in execute
    a_stall: assert property (@(posedge clk) disable iff (reset)
        ds_valid && es_hit && es_fwd.blk && (is_addi || is_st || is_beq || is_bne)
            |-> !ds_to_es_valid && !ds_allowin)
    else begin
        err_count++;
        $error("ERR %0t: load-use hazard did not stall", $time);
    end

    a_go: assert property (@(posedge clk) disable iff (reset)
        ds_valid && !(es_fwd.valid && es_fwd.blk) |-> ds_to_es_valid)
    else begin
        err_count++;
        $error("ERR %0t: instruction held without a hazard", $time);
    end

    // same register on both sides means equal operands
    a_beq: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && is_beq && rj == rkd |-> br.taken && br.target == beq_target)
    else begin
        err_count++;
        $error("ERR %0t: beq target %h, expected %h", $time, br.target, beq_target);
    end

    a_bne: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && is_bne && rj == rkd |-> !br.taken)
    else begin
        err_count++;
        $error("ERR %0t: bne taken on equal operands", $time);
    end

    a_bl: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && is_bl
            |-> br.taken && ds_to_es.ctrl.gr_we && ds_to_es.ctrl.dest == `LINK_REG)
    else begin
        err_count++;
        $error("ERR %0t: bl not taken or link write wrong", $time);
    end

    a_taken: assert property (@(posedge clk) disable iff (reset)
        br.taken |-> ds_to_es_valid)
    else begin
        err_count++;
        $error("ERR %0t: branch taken without a valid packet", $time);
    end

    // wrong-path packet from fetch never reaches execute
    a_drop: assert property (@(posedge clk) disable iff (reset)
        br.cancel |=> !ds_to_es_valid)
    else begin
        err_count++;
        $error("ERR %0t: packet after a taken branch was not dropped", $time);
    end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> $stable(ds_to_es))
    else begin
        err_count++;
        $error("ERR %0t: packet changed under back-pressure", $time);
    end

    a_cancel: assert property (@(posedge clk) disable iff (reset)
        !es_allowin |-> !br.cancel)
    else begin
        err_count++;
        $error("ERR %0t: cancel raised while execute is full", $time);
    end

endmodule

bind id_stage id_stage_sva u_sva (.*);

//--- inst_decoder.sv
`include "decode_macros.svh"

module inst_decoder import decode_pkg::*; (
    input  inst_u                      inst,
    output ctrl_t                      ctrl,
    output logic [`XLEN-1:0]           imm,
    output br_kind_t                   br_kind,
    output logic [`XLEN-1:0]           br_offs,
    output logic [1:0][`REG_AW-1:0]    raddr,
    output logic [1:0]                 rused
);

    logic       r3, shi;
    logic       i_add, i_sub, i_slt, i_sltu, i_nor, i_and, i_or, i_xor;
    logic       i_sll, i_srl, i_sra, i_slli, i_srli, i_srai;
    logic       i_addi, i_slti, i_sltui, i_andi, i_ori, i_xori;
    logic       i_lu12i, i_pcadd;
    logic [4:0] ld;
    logic [2:0] st;
    logic       is_ld, is_st, cond_br, link, known;
    logic [5:0] op6;
    logic [9:0] op10;
    logic [4:0] op5;
    logic [25:0] i26;
    alu_op_t    alu_op;

    assign op6  = inst.fmt_3r.op6;
    assign op5  = inst.fmt_3r.op5;
    assign op10 = inst.fmt_2ri12.opcode;
    assign i26  = {inst.fmt_2ri16.rj, inst.fmt_2ri16.rd, inst.fmt_2ri16.i16};

    assign r3  = op6 == `OP6_ALU && inst.fmt_3r.op4 == `OP4_3R && inst.fmt_3r.op2 == `OP2_3R;
    assign shi = op6 == `OP6_ALU && inst.fmt_3r.op4 == `OP4_SHI && inst.fmt_3r.op2 == `OP2_SHI;

    assign i_add  = r3 && op5 == `OP5_ADD;
    assign i_sub  = r3 && op5 == `OP5_SUB;
    assign i_slt  = r3 && op5 == `OP5_SLT;
    assign i_sltu = r3 && op5 == `OP5_SLTU;
    assign i_nor  = r3 && op5 == `OP5_NOR;
    assign i_and  = r3 && op5 == `OP5_AND;
    assign i_or   = r3 && op5 == `OP5_OR;
    assign i_xor  = r3 && op5 == `OP5_XOR;
    assign i_sll  = r3 && op5 == `OP5_SLL;
    assign i_srl  = r3 && op5 == `OP5_SRL;
    assign i_sra  = r3 && op5 == `OP5_SRA;
    assign i_slli = shi && op5 == `OP5_SLLI;
    assign i_srli = shi && op5 == `OP5_SRLI;
    assign i_srai = shi && op5 == `OP5_SRAI;

    assign i_addi  = op10 == {`OP6_ALU, `OP4_ADDI};
    assign i_slti  = op10 == {`OP6_ALU, `OP4_SLTI};
    assign i_sltui = op10 == {`OP6_ALU, `OP4_SLTUI};
    assign i_andi  = op10 == {`OP6_ALU, `OP4_ANDI};
    assign i_ori   = op10 == {`OP6_ALU, `OP4_ORI};
    assign i_xori  = op10 == {`OP6_ALU, `OP4_XORI};
    assign i_lu12i = inst.fmt_1ri20.opcode == {`OP6_LU12I, 1'b0};
    assign i_pcadd = inst.fmt_1ri20.opcode == {`OP6_PCADDU12I, 1'b0};

    assign ld = {op10 == {`OP6_MEM, `OP4_LD_HU}, op10 == {`OP6_MEM, `OP4_LD_BU},
                 op10 == {`OP6_MEM, `OP4_LD_W}, op10 == {`OP6_MEM, `OP4_LD_H},
                 op10 == {`OP6_MEM, `OP4_LD_B}};
    assign st = {op10 == {`OP6_MEM, `OP4_ST_W}, op10 == {`OP6_MEM, `OP4_ST_H},
                 op10 == {`OP6_MEM, `OP4_ST_B}};
    assign is_ld = |ld;
    assign is_st = |st;

    always_comb begin
        case (inst.fmt_2ri16.opcode)
            `OP6_BEQ:  br_kind = BR_BEQ;
            `OP6_BNE:  br_kind = BR_BNE;
            `OP6_BLT:  br_kind = BR_BLT;
            `OP6_BGE:  br_kind = BR_BGE;
            `OP6_BLTU: br_kind = BR_BLTU;
            `OP6_BGEU: br_kind = BR_BGEU;
            `OP6_B:    br_kind = BR_B;
            `OP6_BL:   br_kind = BR_BL;
            `OP6_JIRL: br_kind = BR_JIRL;
            default:   br_kind = BR_NONE;
        endcase
    end

    assign cond_br = br_kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    assign link    = br_kind == BR_BL || br_kind == BR_JIRL;
    assign known   = r3 || shi || i_addi || i_slti || i_sltui || i_andi || i_ori || i_xori
                   || i_lu12i || i_pcadd || is_ld || is_st || br_kind != BR_NONE;

    // one-hot, bit 0 is the adder for address and link computation too
    assign alu_op = {i_lu12i, i_sra | i_srai, i_srl | i_srli, i_sll | i_slli, i_xor | i_xori,
                     i_or | i_ori, i_nor, i_and | i_andi, i_sltu | i_sltui, i_slt | i_slti,
                     i_sub, i_add | i_addi | is_ld | is_st | link | i_pcadd};

    assign ctrl = '{
        alu_op:       alu_op,
        load_op:      ld,
        store_op:     st,
        res_from_mem: is_ld,
        src1_is_pc:   link | i_pcadd,
        src2_is_imm:  shi | i_addi | i_slti | i_sltui | i_andi | i_ori | i_xori
                      | i_lu12i | i_pcadd | is_ld | is_st | link,
        gr_we:        known && !is_st && !cond_br && br_kind != BR_B,
        mem_we:       is_st,
        dest:         br_kind == BR_BL ? `LINK_REG : inst.fmt_3r.rd
    };

    always_comb begin
        if (i_lu12i || i_pcadd) begin
            imm = {inst.fmt_1ri20.i20, 12'b0};
        end else if (link) begin
            imm = `XLEN'd4;
        end else if (shi) begin
            imm = {{(`XLEN-5){1'b0}}, inst.fmt_3r.rk};
        end else if (i_andi || i_ori || i_xori) begin
            imm = {{(`XLEN-12){1'b0}}, inst.fmt_2ri12.i12};
        end else begin
            imm = {{(`XLEN-12){inst.fmt_2ri12.i12[11]}}, inst.fmt_2ri12.i12};
        end
    end

    assign br_offs = (br_kind == BR_B || br_kind == BR_BL)
                   ? {{(`XLEN-28){i26[25]}}, i26, `IMM_SHIFT_BR}
                   : {{(`XLEN-18){inst.fmt_2ri16.i16[15]}}, inst.fmt_2ri16.i16, `IMM_SHIFT_BR};

    // port 1 reads rd for stores and compares
    assign raddr[0] = inst.fmt_3r.rj;
    assign raddr[1] = (is_st || cond_br) ? inst.fmt_3r.rd : inst.fmt_3r.rk;
    assign rused[0] = known && !i_lu12i && !i_pcadd && br_kind != BR_B && br_kind != BR_BL;
    assign rused[1] = r3 || is_st || cond_br;

endmodule

//--- operand_fwd.sv
`include "decode_macros.svh"

module operand_fwd import decode_pkg::*; (
    input  logic [`REG_AW-1:0] addr,
    input  logic               used,
    input  logic [`XLEN-1:0]   rf_value,
    input  fwd_t               es_fwd,
    input  fwd_t               ms_fwd,
    input  wb_t                wb,
    output logic [`XLEN-1:0]   value,
    output logic               hazard
);

    logic nz;
    logic es_hit;
    logic ms_hit;
    logic wb_hit;

    assign nz     = addr != '0;
    assign es_hit = nz && es_fwd.valid && es_fwd.dest == addr;
    assign ms_hit = nz && ms_fwd.valid && ms_fwd.dest == addr;
    assign wb_hit = nz && wb.we && wb.waddr == addr;

    // youngest producer wins
    always_comb begin
        if (es_hit) begin
            value = es_fwd.data;
        end else if (ms_hit) begin
            value = ms_fwd.data;
        end else if (wb_hit) begin
            value = wb.wdata;
        end else begin
            value = rf_value;
        end
    end

    // load still in execute, data not there yet
    assign hazard = used && es_hit && es_fwd.blk;

endmodule

//--- regfile.sv
`include "decode_macros.svh"

module regfile import decode_pkg::*; (
    input  logic                       clk,
    input  logic [1:0][`REG_AW-1:0]    raddr,
    output logic [1:0][`XLEN-1:0]      rdata,
    input  wb_t                        wb
);

    logic [`XLEN-1:0] regs [`REG_N];

    always_ff @(posedge clk) begin
        if (wb.we && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // r0 is hardwired, never stored
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (raddr[i] == '0) begin
                rdata[i] = '0;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

endmodule

//--- tb_id_stage.sv
`include "decode_macros.svh"

module tb_id_stage import decode_pkg::*; ();

    // upper bound on the cycles the whole sequence takes
    localparam int STIM_CYCLES = 300;
    localparam int CLK_PERIOD  = 20;
    localparam logic [3:0] ST_OPS [3] = '{`OP4_ST_B, `OP4_ST_H, `OP4_ST_W};

    logic             clk;
    logic             reset;
    logic             fs_to_ds_valid;
    fs_to_ds_t        fs_to_ds;
    logic             ds_allowin;
    logic             es_allowin;
    logic             ds_to_es_valid;
    ds_to_es_t        ds_to_es;
    fwd_t             es_fwd;
    fwd_t             ms_fwd;
    wb_t              wb;
    br_t              br;
    integer           seed;
    logic [`XLEN-1:0] pc;

    id_stage i_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] ri12_word(input logic [9:0] op, input logic [11:0] i12,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {op, i12, rj, rd};
    endfunction

    function automatic logic [31:0] ri16_word(input logic [5:0] op, input logic [15:0] i16,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {op, i16, rj, rd};
    endfunction

    // offs26 is split, low half first
    function automatic logic [31:0] i26_word(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    // present one word until fetch handshake completes
    task automatic send(input logic [31:0] inst);
        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_to_ds       <= {pc, inst};
        pc = pc + 32'd4;
        @(negedge clk);
        while (!ds_allowin) begin
            @(negedge clk);
        end
        @(posedge clk);
        fs_to_ds_valid <= 1'b0;
    endtask

    // returns just before the edge where execute takes the packet
    task automatic drain();
        @(negedge clk);
        while (!(ds_to_es_valid && es_allowin)) begin
            @(negedge clk);
        end
    endtask

    task automatic run_one(input logic [31:0] inst);
        send(inst);
        drain();
    endtask

    initial begin
        wait (i_id_stage.u_sva.err_count != 0);
        $display("Verification failed");
        $fatal(1, "stopped at the first assertion failure");
    end

    initial begin
        #((STIM_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: stimulus did not finish in %0d cycles", STIM_CYCLES + 100);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [11:0] i12;

        seed = 32'h3b9d;
        pc   = 32'h1c00_0000;
        reset          <= 1'b1;
        fs_to_ds_valid <= 1'b0;
        fs_to_ds       <= '0;
        es_allowin     <= 1'b1;
        es_fwd         <= '0;
        ms_fwd         <= '0;
        wb             <= '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // give every register a known value
        for (int r = 1; r < `REG_N; r++) begin
            @(posedge clk);
            wb <= '{we: 1'b1, waddr: 5'(r), wdata: $random(seed)};
        end
        @(posedge clk);
        wb <= '0;

        repeat (24) begin
            ra  = $random(seed);
            rb  = $random(seed);
            i12 = $random(seed);
            run_one(ri12_word({`OP6_ALU, `OP4_ADDI}, i12, ra, rb));
        end

        for (int k = 0; k < 3; k++) begin
            repeat (3) begin
                ra  = $random(seed);
                rb  = $random(seed);
                i12 = $random(seed);
                run_one(ri12_word({`OP6_MEM, ST_OPS[k]}, i12, ra, rb));
            end
        end

        // both bypass sources hit, then memory alone
        @(posedge clk);
        es_fwd <= '{valid: 1'b1, blk: 1'b0, dest: 5'd7, data: $random(seed)};
        ms_fwd <= '{valid: 1'b1, blk: 1'b0, dest: 5'd7, data: $random(seed)};
        run_one(ri12_word({`OP6_ALU, `OP4_ADDI}, 12'h010, 5'd7, 5'd8));
        @(posedge clk);
        es_fwd <= '0;
        run_one(ri12_word({`OP6_ALU, `OP4_ADDI}, 12'h020, 5'd7, 5'd9));
        @(posedge clk);
        ms_fwd <= '0;

        @(posedge clk);
        wb <= '{we: 1'b1, waddr: 5'd12, wdata: $random(seed)};
        @(posedge clk);
        wb <= '0;
        run_one(ri12_word({`OP6_ALU, `OP4_ADDI}, 12'h001, 5'd12, 5'd13));

        // load in execute targets rj
        @(posedge clk);
        es_fwd <= '{valid: 1'b1, blk: 1'b1, dest: 5'd3, data: $random(seed)};
        send(ri12_word({`OP6_ALU, `OP4_ADDI}, 12'h7ff, 5'd3, 5'd4));
        repeat (4) @(posedge clk);
        es_fwd.blk <= 1'b0;
        drain();
        @(posedge clk);
        es_fwd <= '0;

        run_one(ri16_word(`OP6_BEQ, 16'h0040, 5'd5, 5'd5));
        run_one(ri16_word(`OP6_BEQ, 16'hfff0, 5'd0, 5'd0));
        run_one(ri16_word(`OP6_BNE, 16'h0010, 5'd6, 5'd6));
        run_one(i26_word(`OP6_BL, 26'h0000123));
        repeat (4) begin
            ra = $random(seed);
            rb = $random(seed);
            run_one(ri16_word(`OP6_BEQ, 16'h0020, ra, rb));
        end

        // execute full, branch must wait while fetch offers the next word
        @(posedge clk);
        es_allowin <= 1'b0;
        send(ri16_word(`OP6_BEQ, 16'h0008, 5'd9, 5'd9));
        fs_to_ds_valid <= 1'b1;
        fs_to_ds       <= {pc, ri12_word({`OP6_ALU, `OP4_ADDI}, 12'h003, 5'd1, 5'd2)};
        repeat (5) @(posedge clk);
        es_allowin <= 1'b1;
        drain();
        @(posedge clk);
        fs_to_ds_valid <= 1'b0;

        repeat (5) @(posedge clk);
        if (i_id_stage.u_sva.err_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "assertion errors were reported");
        end
    end

endmodule
